//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int INSTR_BYTES = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    localparam word_t PC_START = 32'h2040_0000;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_LOAD,
        ST_WRITEBACK
    } stage_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        C_LUI,
        C_AUIPC,
        C_JAL,
        C_JALR,
        C_BRANCH,
        C_ALU_IMM,
        C_ALU_REG,
        C_LOAD,
        C_NOP
    } instr_class_e;

endpackage

//--- design/rv_bus_master.sv
`timescale 1ns/1ps

module rv_bus_master (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_req,
    input  rv_pkg::word_t i_addr,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr,
    output logic          o_done,
    output rv_pkg::word_t o_rdata
);
    import rv_pkg::*;

    logic ack_taken;

    // slave answers only when it is not stalling
    assign ack_taken = o_cyc && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc  <= 1'b0;
            o_stb  <= 1'b0;
            o_addr <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= ack_taken;
            if (i_req) begin
                o_cyc  <= 1'b1;
                o_stb  <= 1'b1;
                o_addr <= i_addr;
            end else begin
                // request accepted
                if (o_stb && !i_stall) begin
                    o_stb <= 1'b0;
                end
                if (ack_taken) begin
                    o_cyc <= 1'b0;
                    o_stb <= 1'b0;
                end
            end
        end
    end

    // held until the next ack, so writeback can still read it
    always_ff @(posedge i_clk) begin
        if (ack_taken) begin
            o_rdata <= i_data;
        end
    end

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_load,
    input  rv_pkg::word_t        i_instr,
    output rv_pkg::reg_idx_t     o_rs1,
    output rv_pkg::reg_idx_t     o_rs2,
    output rv_pkg::reg_idx_t     o_rd,
    output rv_pkg::word_t        o_imm,
    output rv_pkg::instr_class_e o_class,
    output rv_pkg::alu_op_e      o_alu_op,
    output logic [2:0]           o_funct3
);
    import rv_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic         alt;
    logic         shift_ok;
    logic         reg_ok;
    word_t        imm_i;
    word_t        imm_b;
    word_t        imm_u;
    word_t        imm_j;
    word_t        nxt_imm;
    instr_class_e nxt_class;
    alu_op_e      nxt_op;

    assign opcode = i_instr[6:0];
    assign f3     = i_instr[14:12];
    assign f7     = i_instr[31:25];
    assign alt    = (f7 == F7_ALT);

    assign shift_ok = (f7 == 7'd0) || (alt && f3 == F3_SRL);
    assign reg_ok   = (f7 == 7'd0) || (alt && (f3 == F3_ADD || f3 == F3_SRL));

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'd0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        nxt_imm   = imm_i;
        nxt_class = C_NOP;

        // bit 30 of ADDI is immediate, not funct7
        case (f3)
            F3_ADD:  nxt_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            F3_SLL:  nxt_op = ALU_SLL;
            F3_SLT:  nxt_op = ALU_SLT;
            F3_SLTU: nxt_op = ALU_SLTU;
            F3_XOR:  nxt_op = ALU_XOR;
            F3_SRL:  nxt_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   nxt_op = ALU_OR;
            F3_AND:  nxt_op = ALU_AND;
            default: nxt_op = ALU_ADD;
        endcase

        case (opcode)
            OPC_LUI: begin
                nxt_class = C_LUI;
                nxt_imm   = imm_u;
            end
            OPC_AUIPC: begin
                nxt_class = C_AUIPC;
                nxt_imm   = imm_u;
            end
            OPC_JAL: begin
                nxt_class = C_JAL;
                nxt_imm   = imm_j;
            end
            OPC_JALR: nxt_class = C_JALR;
            OPC_BRANCH: begin
                nxt_imm = imm_b;
                if (f3 == F3_BEQ || f3 == F3_BNE || f3 == F3_BLT ||
                    f3 == F3_BGE || f3 == F3_BLTU || f3 == F3_BGEU) begin
                    nxt_class = C_BRANCH;
                end
            end
            OPC_LOAD: begin
                if (f3 == F3_LB || f3 == F3_LH || f3 == F3_LW ||
                    f3 == F3_LBU || f3 == F3_LHU) begin
                    nxt_class = C_LOAD;
                end
            end
            OPC_OP_IMM: begin
                if (!(f3 == F3_SLL || f3 == F3_SRL) || shift_ok) begin
                    nxt_class = C_ALU_IMM;
                end
            end
            OPC_OP: begin
                if (reg_ok) begin
                    nxt_class = C_ALU_REG;
                end
            end
            default: nxt_class = C_NOP;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_class <= C_NOP;
        end else if (i_load) begin
            o_class <= nxt_class;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_rs1    <= i_instr[19:15];
            o_rs2    <= i_instr[24:20];
            o_rd     <= i_instr[11:7];
            o_imm    <= nxt_imm;
            o_alu_op <= nxt_op;
            o_funct3 <= f3;
        end
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_we,
    input  rv_pkg::reg_idx_t i_waddr,
    input  rv_pkg::reg_idx_t i_raddr1,
    input  rv_pkg::reg_idx_t i_raddr2,
    input  rv_pkg::word_t    i_wdata,
    output rv_pkg::word_t    o_rdata1,
    output rv_pkg::word_t    o_rdata2
);
    import rv_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            // x0 never written, stays zero
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata1 = regs[i_raddr1];
    assign o_rdata2 = regs[i_raddr2];

endmodule

//--- design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::instr_class_e i_class,
    input  rv_pkg::alu_op_e      i_alu_op,
    input  logic [2:0]           i_funct3,
    input  rv_pkg::word_t        i_rs1_val,
    input  rv_pkg::word_t        i_rs2_val,
    input  rv_pkg::word_t        i_imm,
    input  rv_pkg::word_t        i_pc,
    output rv_pkg::word_t        o_result,
    output rv_pkg::word_t        o_next_pc,
    output rv_pkg::word_t        o_mem_addr
);
    import rv_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_out;
    word_t      pc_seq;
    word_t      pc_rel;
    logic       taken;

    assign op_b       = (i_class == C_ALU_REG) ? i_rs2_val : i_imm;
    assign shamt      = op_b[4:0];
    assign pc_seq     = i_pc + INSTR_BYTES;
    assign pc_rel     = i_pc + i_imm;
    // load address, also the JALR target before bit 0 is cleared
    assign o_mem_addr = i_rs1_val + i_imm;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:  alu_out = i_rs1_val + op_b;
            ALU_SUB:  alu_out = i_rs1_val - op_b;
            ALU_SLL:  alu_out = i_rs1_val << shamt;
            ALU_SLT:  alu_out = {31'd0, $signed(i_rs1_val) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'd0, i_rs1_val < op_b};
            ALU_XOR:  alu_out = i_rs1_val ^ op_b;
            ALU_SRL:  alu_out = i_rs1_val >> shamt;
            ALU_SRA:  alu_out = $unsigned($signed(i_rs1_val) >>> shamt);
            ALU_OR:   alu_out = i_rs1_val | op_b;
            ALU_AND:  alu_out = i_rs1_val & op_b;
            default:  alu_out = i_rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (i_funct3)
            F3_BEQ:  taken = (i_rs1_val == i_rs2_val);
            F3_BNE:  taken = (i_rs1_val != i_rs2_val);
            F3_BLT:  taken = ($signed(i_rs1_val) < $signed(i_rs2_val));
            F3_BGE:  taken = ($signed(i_rs1_val) >= $signed(i_rs2_val));
            F3_BLTU: taken = (i_rs1_val < i_rs2_val);
            F3_BGEU: taken = (i_rs1_val >= i_rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (i_class)
            C_LUI:         o_result = i_imm;
            C_AUIPC:       o_result = pc_rel;
            C_JAL, C_JALR: o_result = pc_seq;
            default:       o_result = alu_out;
        endcase
    end

    always_comb begin
        if (i_class == C_JAL || (i_class == C_BRANCH && taken)) begin
            o_next_pc = pc_rel;
        end else if (i_class == C_JALR) begin
            o_next_pc = {o_mem_addr[XLEN-1:1], 1'b0};
        end else begin
            o_next_pc = pc_seq;
        end
    end

endmodule

//--- design/rv_load_align.sv
`timescale 1ns/1ps

module rv_load_align (
    input  rv_pkg::word_t i_word,
    input  logic [1:0]    i_byte_off,
    input  logic [2:0]    i_funct3,
    output rv_pkg::word_t o_value
);
    import rv_pkg::*;

    word_t       shifted;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane 0 lands in the low bits
    assign shifted   = i_word >> {i_byte_off, 3'b000};
    assign byte_lane = shifted[7:0];
    assign half_lane = i_byte_off[1] ? i_word[31:16] : i_word[15:0];

    always_comb begin
        case (i_funct3)
            F3_LB:   o_value = {{24{byte_lane[7]}}, byte_lane};
            F3_LBU:  o_value = {24'd0, byte_lane};
            F3_LH:   o_value = {{16{half_lane[15]}}, half_lane};
            F3_LHU:  o_value = {16'd0, half_lane};
            F3_LW:   o_value = i_word;
            default: o_value = i_word;
        endcase
    end

endmodule

//--- design/rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_done,
    input  rv_pkg::instr_class_e i_class,
    input  rv_pkg::reg_idx_t     i_rd,
    input  rv_pkg::word_t        i_result,
    input  rv_pkg::word_t        i_next_pc,
    input  rv_pkg::word_t        i_mem_addr,
    input  rv_pkg::word_t        i_load_value,
    output logic                 o_req,
    output rv_pkg::word_t        o_req_addr,
    output rv_pkg::word_t        o_pc,
    output logic                 o_load_instr,
    output logic [1:0]           o_byte_off,
    output logic                 o_rf_we,
    output rv_pkg::reg_idx_t     o_rf_waddr,
    output rv_pkg::word_t        o_rf_wdata
);
    import rv_pkg::*;

    stage_e state;
    logic   is_load;
    logic   writes_rd;

    assign is_load = (i_class == C_LOAD);

    always_comb begin
        case (i_class)
            C_LUI, C_AUIPC, C_JAL, C_JALR, C_ALU_IMM, C_ALU_REG: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // fetch from pc, or load from rs1+imm at the end of execute
    assign o_req        = (state == ST_FETCH) || (state == ST_EXECUTE && is_load);
    assign o_req_addr   = (state == ST_FETCH) ? o_pc : i_mem_addr;
    assign o_load_instr = (state == ST_DECODE) && i_done;

    assign o_rf_we    = (state == ST_EXECUTE && writes_rd) || (state == ST_WRITEBACK);
    assign o_rf_waddr = i_rd;
    assign o_rf_wdata = (state == ST_WRITEBACK) ? i_load_value : i_result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= ST_FETCH;
            o_pc  <= PC_START;
        end else begin
            case (state)
                ST_FETCH: state <= ST_DECODE;
                ST_DECODE: begin
                    if (i_done) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    o_pc  <= i_next_pc;
                    state <= is_load ? ST_LOAD : ST_FETCH;
                end
                ST_LOAD: begin
                    if (i_done) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: state <= ST_FETCH;
                default: state <= ST_FETCH;
            endcase
        end
    end

    // lane offset held for the aligner until writeback
    always_ff @(posedge i_clk) begin
        if (state == ST_EXECUTE && is_load) begin
            o_byte_off <= i_mem_addr[1:0];
        end
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr
);
    import rv_pkg::*;

    logic         req;
    word_t        req_addr;
    logic         done;
    word_t        rdata;
    logic         load_instr;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    instr_class_e cls;
    alu_op_e      alu_op;
    logic [2:0]   funct3;
    word_t        rs1_val;
    word_t        rs2_val;
    word_t        result;
    word_t        next_pc;
    word_t        mem_addr;
    word_t        pc;
    logic [1:0]   byte_off;
    word_t        load_value;
    logic         rf_we;
    reg_idx_t     rf_waddr;
    word_t        rf_wdata;

    rv_bus_master u_bus_master (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (req),
        .i_addr  (req_addr),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr),
        .o_done  (done),
        .o_rdata (rdata)
    );

    rv_decoder u_decoder (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_load   (load_instr),
        .i_instr  (rdata),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .o_rd     (rd),
        .o_imm    (imm),
        .o_class  (cls),
        .o_alu_op (alu_op),
        .o_funct3 (funct3)
    );

    rv_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_done       (done),
        .i_class      (cls),
        .i_rd         (rd),
        .i_result     (result),
        .i_next_pc    (next_pc),
        .i_mem_addr   (mem_addr),
        .i_load_value (load_value),
        .o_req        (req),
        .o_req_addr   (req_addr),
        .o_pc         (pc),
        .o_load_instr (load_instr),
        .o_byte_off   (byte_off),
        .o_rf_we      (rf_we),
        .o_rf_waddr   (rf_waddr),
        .o_rf_wdata   (rf_wdata)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (rf_we),
        .i_waddr  (rf_waddr),
        .i_raddr1 (rs1),
        .i_raddr2 (rs2),
        .i_wdata  (rf_wdata),
        .o_rdata1 (rs1_val),
        .o_rdata2 (rs2_val)
    );

    rv_alu u_alu (
        .i_class    (cls),
        .i_alu_op   (alu_op),
        .i_funct3   (funct3),
        .i_rs1_val  (rs1_val),
        .i_rs2_val  (rs2_val),
        .i_imm      (imm),
        .i_pc       (pc),
        .o_result   (result),
        .o_next_pc  (next_pc),
        .o_mem_addr (mem_addr)
    );

    rv_load_align u_load_align (
        .i_word     (rdata),
        .i_byte_off (byte_off),
        .i_funct3   (funct3),
        .o_value    (load_value)
    );

endmodule

//--- testbench/rv_core_chk.sv
`timescale 1ns/1ps

module rv_core_chk (
    input logic          i_clk,
    input logic          i_rst,
    input logic          i_cyc,
    input logic          i_stb,
    input rv_pkg::word_t i_addr
);
    import rv_pkg::*;

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) i_stb |-> i_cyc)
        else $error("strobe high outside an open bus cycle");

    a_addr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_cyc && $past(i_cyc)) |-> $stable(i_addr))
        else $error("address changed during an open bus cycle");

    a_idle_in_reset: assert property (@(posedge i_clk) (i_rst && $past(i_rst)) |-> (!i_cyc && !i_stb))
        else $error("bus not idle during reset");

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int SEG1  = 4,
    parameter int SEG2  = 48,
    parameter int SEG3  = 80,
    parameter int SEG4  = 96,
    parameter int END_W = 128
) (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_cyc,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_addr,
    input  rv_pkg::word_t i_data,
    output int            o_tests,
    output int            o_failed_tests,
    output int            o_checks,
    output int            o_errors,
    output logic          o_finished
);
    import rv_pkg::*;

    string      test_name [5] = '{"fetch_seq", "alu_ops", "branches", "jumps", "loads"};
    word_t      mregs [NUM_REGS];
    word_t      mpc;
    word_t      expected;
    logic       load_phase;
    reg_idx_t   pend_rd;
    logic [2:0] pend_f3;
    logic [1:0] pend_off;
    logic       cyc_q;
    int         cur;
    int         seg_errs;
    word_t      val;

    function automatic word_t seg_addr(int k);
        case (k)
            0:       return PC_START;
            1:       return PC_START + SEG1 * 4;
            2:       return PC_START + SEG2 * 4;
            3:       return PC_START + SEG3 * 4;
            4:       return PC_START + SEG4 * 4;
            default: return PC_START + END_W * 4;
        endcase
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SRL:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t extend_load(word_t w, logic [2:0] f3, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{off, 3'b000} +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (f3)
            F3_LB:   return {{24{b[7]}}, b};
            F3_LBU:  return {24'd0, b};
            F3_LH:   return {{16{h[15]}}, h};
            F3_LHU:  return {16'd0, h};
            default: return w;
        endcase
    endfunction

    // one instruction of the model, returns the next bus address
    function automatic word_t step_model(word_t ins);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        word_t      res;
        word_t      nxt;
        logic       wr;
        logic       tk;
        opc   = ins[6:0];
        f3    = ins[14:12];
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt   = mpc + 4;
        res   = '0;
        wr    = 1'b1;
        tk    = 1'b0;
        case (opc)
            OPC_LUI:   res = {ins[31:12], 12'd0};
            OPC_AUIPC: res = mpc + {ins[31:12], 12'd0};
            OPC_JAL: begin
                res = mpc + 4;
                nxt = mpc + imm_j;
            end
            OPC_JALR: begin
                res = mpc + 4;
                nxt = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    F3_BEQ:  tk = (a == b);
                    F3_BNE:  tk = (a != b);
                    F3_BLT:  tk = ($signed(a) < $signed(b));
                    F3_BGE:  tk = ($signed(a) >= $signed(b));
                    F3_BLTU: tk = (a < b);
                    default: tk = (a >= b);
                endcase
                if (tk) begin
                    nxt = mpc + imm_b;
                end
            end
            OPC_OP_IMM: res = alu_ref(f3, ins[30] && f3 == F3_SRL, a, imm_i);
            OPC_OP:     res = alu_ref(f3, ins[30], a, b);
            OPC_LOAD: begin
                wr         = 1'b0;
                load_phase = 1'b1;
                pend_rd    = ins[11:7];
                pend_f3    = f3;
                pend_off   = a[1:0] + imm_i[1:0];
            end
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            mregs[ins[11:7]] = res;
        end
        mpc = nxt;
        return load_phase ? a + imm_i : nxt;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                mregs[i] = '0;
            end
            mpc            = PC_START;
            expected       = PC_START;
            load_phase     = 1'b0;
            cyc_q          = 1'b0;
            cur            = 0;
            seg_errs       = 0;
            o_tests        = 0;
            o_failed_tests = 0;
            o_checks       = 0;
            o_errors       = 0;
            o_finished     = 1'b0;
        end else begin
            if (i_cyc && !cyc_q) begin
                o_checks++;
                if (!load_phase && !o_finished && i_addr == seg_addr(cur + 1)) begin
                    $display("test %0s: %0s (%0d errors)", test_name[cur],
                             seg_errs == 0 ? "ok" : "mismatch", seg_errs);
                    o_tests++;
                    if (seg_errs != 0) begin
                        o_failed_tests++;
                    end
                    seg_errs = 0;
                    cur++;
                    o_finished = (cur == 5);
                end
                if (i_addr !== expected && !o_finished) begin
                    o_errors++;
                    seg_errs++;
                    $display("Error: test %0s expected %h actual %h",
                             test_name[cur], expected, i_addr);
                end
            end
            if (i_cyc && i_ack && !i_stall) begin
                if (load_phase) begin
                    val = extend_load(i_data, pend_f3, pend_off);
                    if (pend_rd != 5'd0) begin
                        mregs[pend_rd] = val;
                    end
                    load_phase = 1'b0;
                    expected   = mpc;
                end else begin
                    expected = step_model(i_data);
                end
            end
            cyc_q = i_cyc;
        end
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import rv_pkg::*;

    localparam int PROG_WORDS = 132;
    localparam int SEG1       = 4;
    localparam int SEG2       = 48;
    localparam int SEG3       = 80;
    localparam int SEG4       = 96;
    localparam int END_W      = 128;
    localparam int MAX_WAIT   = 3;
    // req to cyc, stall and ack waits, done
    localparam int WORST_LAT  = 2 * MAX_WAIT + 4;
    localparam int TIMEOUT    = PROG_WORDS * (2 * WORST_LAT + 4) * 2;

    logic  i_clk;
    logic  i_rst;
    logic  i_ack;
    logic  i_stall;
    word_t i_data;
    logic  o_cyc;
    logic  o_stb;
    word_t o_addr;

    word_t prog [PROG_WORDS];
    int    wp;
    int    seed;
    int    cycle_cnt;
    logic  busy;
    int    stall_left;
    int    wait_left;
    int    tests;
    int    failed_tests;
    int    checks;
    int    errors;
    logic  finished;

    rv_core u_rv_core (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    bind rv_core rv_core_chk u_rv_core_chk (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_cyc  (o_cyc),
        .i_stb  (o_stb),
        .i_addr (o_addr)
    );

    tb_checker #(
        .SEG1  (SEG1),
        .SEG2  (SEG2),
        .SEG3  (SEG3),
        .SEG4  (SEG4),
        .END_W (END_W)
    ) u_checker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_cyc          (o_cyc),
        .i_ack          (i_ack),
        .i_stall        (i_stall),
        .i_addr         (o_addr),
        .i_data         (i_data),
        .o_tests        (tests),
        .o_failed_tests (failed_tests),
        .o_checks       (checks),
        .o_errors       (errors),
        .o_finished     (finished)
    );

    always #4 i_clk = ~i_clk;

    function automatic word_t enc_i(logic [6:0] opc, int rd, logic [2:0] f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_b(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [6:0] opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t enc_j(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // data outside the program area
    function automatic word_t mem_word(word_t addr);
        word_t off;
        off = addr - PC_START;
        if (addr >= PC_START && off < PROG_WORDS * 4) begin
            return prog[off[31:2]];
        end
        return {addr[31:24] ^ 8'h8C, addr[23:16] ^ 8'h7B, addr[15:8] ^ 8'h96, addr[7:0] ^ 8'hE1};
    endfunction

    task automatic put(word_t w);
        prog[wp] = w;
        wp++;
    endtask

    // lbu x31 from rd+1 exposes rd on the bus
    task automatic probe(int rd);
        put(enc_i(OPC_LOAD, 31, F3_LBU, rd, 1));
    endtask

    task automatic op_probe(word_t w, int rd);
        put(w);
        probe(rd);
    endtask

    task automatic branch_pair(logic [2:0] f3, int ta, int tb, int na, int nb);
        put(enc_b(f3, ta, tb, 8));
        put(enc_i(OPC_OP_IMM, 0, F3_ADD, 0, 0));
        put(enc_b(f3, na, nb, 8));
        put(enc_i(OPC_OP_IMM, 0, F3_ADD, 0, 0));
    endtask

    task automatic load_probe(logic [2:0] f3, int off);
        put(enc_i(OPC_LOAD, 25, f3, 24, off));
        probe(25);
    endtask

    task automatic load_program;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = enc_i(OPC_OP_IMM, 0, F3_ADD, 0, 0);
        end
        wp = SEG1;
        op_probe(enc_i(OPC_OP_IMM, 1, F3_ADD, 0, 'h123), 1);
        op_probe(enc_i(OPC_OP_IMM, 2, F3_ADD, 0, -5), 2);
        op_probe(enc_r(F7_ALT, 2, 1, F3_ADD, 3), 3);
        op_probe(enc_r(7'd0, 1, 2, F3_SLT, 4), 4);
        op_probe(enc_r(7'd0, 2, 1, F3_SLTU, 5), 5);
        op_probe(enc_i(OPC_OP_IMM, 6, F3_SLL, 1, 7), 6);
        op_probe(enc_i(OPC_OP_IMM, 7, F3_SRL, 2, 3), 7);
        op_probe(enc_i(OPC_OP_IMM, 8, F3_SRL, 2, 'h402), 8);
        op_probe(enc_r(7'd0, 1, 2, F3_SLL, 9), 9);
        op_probe(enc_r(7'd0, 1, 2, F3_SRL, 10), 10);
        op_probe(enc_r(F7_ALT, 1, 2, F3_SRL, 11), 11);
        op_probe(enc_i(OPC_OP_IMM, 12, F3_XOR, 1, 'h7ff), 12);
        op_probe(enc_r(7'd0, 2, 1, F3_OR, 13), 13);
        op_probe(enc_i(OPC_OP_IMM, 14, F3_AND, 2, 'h0f0), 14);
        op_probe(enc_i(OPC_OP_IMM, 15, F3_SLT, 2, 1), 15);
        op_probe(enc_i(OPC_OP_IMM, 16, F3_SLTU, 1, -1), 16);
        op_probe(enc_r(7'd0, 3, 1, F3_ADD, 17), 17);
        op_probe(enc_r(7'd0, 3, 2, F3_XOR, 18), 18);
        op_probe(enc_r(7'd0, 2, 1, F3_AND, 19), 19);
        // x0 keeps zero after a write
        op_probe(enc_i(OPC_OP_IMM, 0, F3_ADD, 1, 5), 0);
        // compares that come out false
        op_probe(enc_r(7'd0, 2, 1, F3_SLT, 20), 20);
        op_probe(enc_r(7'd0, 1, 2, F3_SLTU, 21), 21);
        // x1 small positive, x2 negative
        wp = SEG2;
        branch_pair(F3_BEQ, 1, 1, 1, 2);
        branch_pair(F3_BNE, 1, 2, 1, 1);
        branch_pair(F3_BLT, 2, 1, 1, 2);
        branch_pair(F3_BGE, 1, 2, 2, 1);
        branch_pair(F3_BLTU, 1, 2, 2, 1);
        branch_pair(F3_BGEU, 2, 1, 1, 2);
        wp = SEG3;
        put(enc_j(20, 8));
        put(enc_i(OPC_OP_IMM, 0, F3_ADD, 0, 0));
        probe(20);
        op_probe(enc_u(OPC_AUIPC, 21, 'h12345), 21);
        op_probe(enc_u(OPC_LUI, 22, 'hABCDE), 22);
        // odd offset, bit 0 of the target is dropped
        put(enc_i(OPC_JALR, 23, 3'b000, 20, 33));
        put(enc_i(OPC_OP_IMM, 0, F3_ADD, 0, 0));
        probe(23);
        wp = SEG4;
        put(enc_u(OPC_LUI, 24, 'h30000));
        for (int off = 0; off < 4; off++) begin
            load_probe(F3_LB, off);
            load_probe(F3_LBU, off);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_probe(F3_LH, off);
            load_probe(F3_LHU, off);
        end
        load_probe(F3_LW, 0);
        prog[END_W] = enc_j(0, 0);
    endtask

    // slave with random stall and ack wait per request
    always @(negedge i_clk) begin
        if (i_rst) begin
            busy    = 1'b0;
            i_ack   = 1'b0;
            i_stall = 1'b0;
        end else begin
            i_ack   = 1'b0;
            i_stall = 1'b0;
            if (!busy && o_cyc && o_stb) begin
                busy       = 1'b1;
                stall_left = $unsigned($random(seed)) % (MAX_WAIT + 1);
                wait_left  = $unsigned($random(seed)) % (MAX_WAIT + 1);
            end
            if (busy) begin
                if (stall_left > 0) begin
                    i_stall = 1'b1;
                    stall_left--;
                end else if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    i_ack  = 1'b1;
                    i_data = mem_word(o_addr);
                    busy   = 1'b0;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: the core did not reach the end of the program in %0d cycles",
                     TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed      = 11;
        cycle_cnt = 0;
        i_clk     = 1'b0;
        i_rst     = 1'b1;
        i_ack     = 1'b0;
        i_stall   = 1'b0;
        i_data    = '0;
        busy      = 1'b0;
        load_program();
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        wait (finished);
        @(posedge i_clk);
        $display("tests %0d, failed tests %0d, address checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && failed_tests == 0 && checks > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
design/rv_pkg.sv
design/rv_bus_master.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_load_align.sv
design/rv_sequencer.sv
design/rv_core.sv
testbench/rv_core_chk.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
